// ==== all.f ====
hw/mem_map_pkg.sv
hw/addr_rule_match.sv
hw/resp_route_fifo.sv
hw/addr_demux.sv
hw/sram_target.sv
hw/err_target.sv
hw/mem_subsys_top.sv
sim/tb_clk_gen.sv
sim/tb_mem_subsys.sv

// ==== hw/addr_demux.sv ====
/* request steering by address rule, read gating on route FIFO space
   and in-order response selection by FIFO head */
module addr_demux (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  // requester side
  input  logic [mem_map_pkg::ADDR_W-1:0]                             req_addr_i,
  input  logic                                                       req_write_i,
  input  logic                                                       req_valid_i,
  output logic                                                       req_ready_o,
  // rule table
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0]  map_base_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0]  map_mask_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::TGT_IDX_W-1:0] map_tgt_i,
  // target side
  output logic [mem_map_pkg::NR_TARGETS-1:0]                         tgt_req_valid_o,
  input  logic [mem_map_pkg::NR_TARGETS-1:0]                         tgt_req_ready_i,
  input  logic [mem_map_pkg::NR_TARGETS-1:0]                         tgt_resp_valid_i,
  input  logic [mem_map_pkg::NR_TARGETS-1:0][mem_map_pkg::DATA_W-1:0] tgt_resp_rdata_i,
  output logic [mem_map_pkg::NR_TARGETS-1:0]                         tgt_resp_ready_o,
  // response back to the requester
  output logic                                                       resp_valid_o,
  output logic [mem_map_pkg::DATA_W-1:0]                             resp_rdata_o,
  input  logic                                                       resp_ready_i
);

  import mem_map_pkg::*;

  logic [TGT_IDX_W-1:0]  tgt_idx;
  logic [NR_TARGETS-1:0] tgt_sel;
  logic [NR_TARGETS-1:0] head_route;
  logic                  route_full;
  logic                  route_empty;
  logic                  read_blocked;
  logic                  push_route;
  logic                  pop_route;

  addr_rule_match u_rule_match (
    .addr_i     (req_addr_i),
    .map_base_i (map_base_i),
    .map_mask_i (map_mask_i),
    .map_tgt_i  (map_tgt_i),
    .tgt_idx_o  (tgt_idx)
  );

  always_comb begin
    for (int i = 0; i < NR_TARGETS; i++) begin
      tgt_sel[i] = (tgt_idx == TGT_IDX_W'(i));
    end
  end

  // a read needs a free route slot, writes never do
  assign read_blocked = !req_write_i && route_full;

  assign tgt_req_valid_o = (req_valid_i && !read_blocked) ? tgt_sel : '0;
  assign req_ready_o     = |(tgt_sel & tgt_req_ready_i) && !read_blocked;

  assign push_route = req_valid_i && req_ready_o && !req_write_i;
  assign pop_route  = resp_valid_o && resp_ready_i;

  resp_route_fifo u_route_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push_route),
    .route_i (tgt_sel),
    .pop_i   (pop_route),
    .route_o (head_route),
    .full_o  (route_full),
    .empty_o (route_empty)
  );

  // only the target owning the oldest read may answer
  always_comb begin
    resp_valid_o = 1'b0;
    resp_rdata_o = '0;
    if (!route_empty) begin
      for (int i = 0; i < NR_TARGETS; i++) begin
        if (head_route[i]) begin
          resp_valid_o = tgt_resp_valid_i[i];
          resp_rdata_o = tgt_resp_rdata_i[i];
        end
      end
    end
  end

  // Other targets see ready low and keep their responses.
  assign tgt_resp_ready_o = resp_ready_i ? head_route : '0;

endmodule

// ==== hw/addr_rule_match.sv ====
/* first-match address decoder over the base/mask/target rule table */
module addr_rule_match (
  input  logic [mem_map_pkg::ADDR_W-1:0]                          addr_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0] map_base_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0] map_mask_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::TGT_IDX_W-1:0] map_tgt_i,
  output logic [mem_map_pkg::TGT_IDX_W-1:0]                       tgt_idx_o
);

  import mem_map_pkg::*;

  logic [NR_RULES-1:0] rule_hit;

  // every rule is compared in parallel
  always_comb begin
    for (int i = 0; i < NR_RULES; i++) begin
      rule_hit[i] = ((addr_i & map_mask_i[i]) == map_base_i[i]);
    end
  end

  // priority scan, walking down so the lowest matching rule is the last to write
  // no match at all falls through to the error target
  always_comb begin
    tgt_idx_o = ERR_TGT;
    for (int i = NR_RULES - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        tgt_idx_o = map_tgt_i[i];
      end
    end
  end

endmodule

// ==== hw/err_target.sv ====
/* catch-all target that drops writes and answers reads with
   the fixed error word one cycle later */
module err_target (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_valid_i,
  input  logic                           req_write_i,
  output logic                           req_ready_o,
  output logic                           resp_valid_o,
  output logic [mem_map_pkg::DATA_W-1:0] resp_rdata_o,
  input  logic                           resp_ready_i
);

  import mem_map_pkg::*;

  logic resp_held;
  logic rd_accept;

  // stall everything while an answer is pending
  assign req_ready_o = !resp_held;
  assign rd_accept   = req_valid_i && !req_write_i && !resp_held;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_held <= 1'b0;
    end else if (rd_accept) begin
      resp_held <= 1'b1;
    end else if (resp_ready_i) begin
      resp_held <= 1'b0;
    end
  end

  assign resp_valid_o = resp_held;
  assign resp_rdata_o = resp_held ? ERR_DATA : '0;

endmodule

// ==== hw/mem_map_pkg.sv ====
/* bus widths, target and rule counts, route FIFO sizing,
   bank geometry and the error target's read data */
package mem_map_pkg;

  // request and response bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // target 0 is bank0, 1 is bank1, 2 answers unmapped addresses
  localparam int unsigned NR_TARGETS = 3;
  localparam int unsigned TGT_IDX_W  = 2;
  localparam logic [TGT_IDX_W-1:0] ERR_TGT = 2'd2;

  // routing table size
  localparam int unsigned NR_RULES = 4;

  // outstanding reads tracked by the route FIFO
  localparam int unsigned MAX_OUT_READS = 2;
  localparam int unsigned FIFO_PTR_W    = (MAX_OUT_READS > 1) ? $clog2(MAX_OUT_READS) : 1;
  localparam int unsigned FIFO_CNT_W    = $clog2(MAX_OUT_READS + 1);

  // a bank word is selected by address bits 9 down to 2
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_IDX_W = $clog2(BANK_WORDS);

  // read data returned for unmapped addresses
  localparam logic [DATA_W-1:0] ERR_DATA = 32'hdead_beef;

endpackage

// ==== hw/mem_subsys_top.sv ====
/* memory subsystem top: address demux in front of two SRAM banks
   of different read latency and the error target */
module mem_subsys_top (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  // request channel
  input  logic [mem_map_pkg::ADDR_W-1:0]                             req_addr_i,
  input  logic                                                       req_write_i,
  input  logic [mem_map_pkg::DATA_W-1:0]                             req_wdata_i,
  input  logic                                                       req_valid_i,
  output logic                                                       req_ready_o,
  // response channel
  output logic [mem_map_pkg::DATA_W-1:0]                             resp_rdata_o,
  output logic                                                       resp_valid_o,
  input  logic                                                       resp_ready_i,
  // routing rules
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0]  map_base_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::ADDR_W-1:0]  map_mask_i,
  input  logic [mem_map_pkg::NR_RULES-1:0][mem_map_pkg::TGT_IDX_W-1:0] map_tgt_i
);

  import mem_map_pkg::*;

  logic [NR_TARGETS-1:0]             tgt_req_valid;
  logic [NR_TARGETS-1:0]             tgt_req_ready;
  logic [NR_TARGETS-1:0]             tgt_resp_valid;
  logic [NR_TARGETS-1:0][DATA_W-1:0] tgt_resp_rdata;
  logic [NR_TARGETS-1:0]             tgt_resp_ready;

  addr_demux u_demux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_addr_i       (req_addr_i),
    .req_write_i      (req_write_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .map_base_i       (map_base_i),
    .map_mask_i       (map_mask_i),
    .map_tgt_i        (map_tgt_i),
    .tgt_req_valid_o  (tgt_req_valid),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_resp_valid_i (tgt_resp_valid),
    .tgt_resp_rdata_i (tgt_resp_rdata),
    .tgt_resp_ready_o (tgt_resp_ready),
    .resp_valid_o     (resp_valid_o),
    .resp_rdata_o     (resp_rdata_o),
    .resp_ready_i     (resp_ready_i)
  );

  // bank0 answers one cycle after acceptance
  sram_target #(
    .RESP_DELAY (1)
  ) u_bank0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (tgt_req_valid[0]),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_ready_o  (tgt_req_ready[0]),
    .resp_valid_o (tgt_resp_valid[0]),
    .resp_rdata_o (tgt_resp_rdata[0]),
    .resp_ready_i (tgt_resp_ready[0])
  );

  // bank1 is the slow one
  sram_target #(
    .RESP_DELAY (2)
  ) u_bank1 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (tgt_req_valid[1]),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_ready_o  (tgt_req_ready[1]),
    .resp_valid_o (tgt_resp_valid[1]),
    .resp_rdata_o (tgt_resp_rdata[1]),
    .resp_ready_i (tgt_resp_ready[1])
  );

  err_target u_err (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (tgt_req_valid[ERR_TGT]),
    .req_write_i  (req_write_i),
    .req_ready_o  (tgt_req_ready[ERR_TGT]),
    .resp_valid_o (tgt_resp_valid[ERR_TGT]),
    .resp_rdata_o (tgt_resp_rdata[ERR_TGT]),
    .resp_ready_i (tgt_resp_ready[ERR_TGT])
  );

endmodule

// ==== hw/resp_route_fifo.sv ====
/* circular buffer of one-hot target routes for outstanding reads,
   with full/empty flags and a zeroed head when empty */
module resp_route_fifo (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               push_i,
  input  logic [mem_map_pkg::NR_TARGETS-1:0] route_i,
  input  logic                               pop_i,
  output logic [mem_map_pkg::NR_TARGETS-1:0] route_o,
  output logic                               full_o,
  output logic                               empty_o
);

  import mem_map_pkg::*;

  logic [NR_TARGETS-1:0] mem [MAX_OUT_READS];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(MAX_OUT_READS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count == FIFO_CNT_W'(MAX_OUT_READS));
  assign empty_o = (count == '0);

  // overflow and underflow are ignored rather than corrupting state
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= route_i;
    end
  end

  // head route, all zero selects no target
  assign route_o = empty_o ? '0 : mem[rd_ptr];

endmodule

// ==== hw/sram_target.sv ====
/* word-addressed SRAM bank with posted writes and a stallable
   read-response pipeline of RESP_DELAY stages */
module sram_target #(
  parameter int unsigned RESP_DELAY = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_valid_i,
  input  logic                           req_write_i,
  input  logic [mem_map_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [mem_map_pkg::DATA_W-1:0] req_wdata_i,
  output logic                           req_ready_o,
  output logic                           resp_valid_o,
  output logic [mem_map_pkg::DATA_W-1:0] resp_rdata_o,
  input  logic                           resp_ready_i
);

  import mem_map_pkg::*;

  logic [DATA_W-1:0]                  mem [BANK_WORDS];
  logic [BANK_IDX_W-1:0]              word_idx;
  logic [RESP_DELAY-1:0]              stage_valid;
  logic [RESP_DELAY-1:0][DATA_W-1:0]  stage_data;
  logic                               advance;
  logic                               wr_accept;
  logic                               rd_accept;

  // byte address down to word index
  assign word_idx = req_addr_i[BANK_IDX_W+1:2];

  // whole pipeline moves when the output slot frees up
  assign advance = !stage_valid[RESP_DELAY-1] || resp_ready_i;

  assign req_ready_o = req_write_i ? 1'b1 : advance;
  assign wr_accept   = req_valid_i && req_write_i;
  assign rd_accept   = req_valid_i && !req_write_i && advance;

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem[word_idx] <= req_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid[0] <= rd_accept;
      for (int i = 1; i < RESP_DELAY; i++) begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end
  end

  // data rides alongside the valid bits
  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_data[0] <= mem[word_idx];
      for (int i = 1; i < RESP_DELAY; i++) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  assign resp_valid_o = stage_valid[RESP_DELAY-1];
  assign resp_rdata_o = stage_data[RESP_DELAY-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module tb_mem_subsys -f all.f -o tb_mem_subsys \
  && ./obj_dir/tb_mem_subsys | tee /dev/stderr | grep -q "^Test passed$" \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// ==== sim/tb_clk_gen.sv ====
/* testbench clock and active-low reset generator */
module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 4,
  parameter int unsigned RST_CYCLES  = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge so no rising edge sees it change
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== sim/tb_mem_subsys.sv ====
/* directed testbench for the memory subsystem, with a reference
   model of both banks and an in-order response checker */
module tb_mem_subsys;

  import mem_map_pkg::*;

  localparam int unsigned ACCEPT_TIMEOUT = 50;
  localparam int unsigned DRAIN_TIMEOUT  = 200;
  localparam int unsigned STALL_WINDOW   = 12;
  localparam logic [1:0]  READY_HIGH     = 2'd0;
  localparam logic [1:0]  READY_LOW      = 2'd1;
  localparam logic [1:0]  READY_RANDOM   = 2'd2;

  logic                               clk;
  logic                               rst_n;
  logic [ADDR_W-1:0]                  req_addr;
  logic                               req_write;
  logic [DATA_W-1:0]                  req_wdata;
  logic                               req_valid;
  logic                               req_ready;
  logic [DATA_W-1:0]                  resp_rdata;
  logic                               resp_valid;
  logic                               resp_ready;
  logic [NR_RULES-1:0][ADDR_W-1:0]    map_base;
  logic [NR_RULES-1:0][ADDR_W-1:0]    map_mask;
  logic [NR_RULES-1:0][TGT_IDX_W-1:0] map_tgt;

  logic [DATA_W-1:0] ref_bank0 [BANK_WORDS];
  logic [DATA_W-1:0] ref_bank1 [BANK_WORDS];
  logic [DATA_W-1:0] exp_q [$];
  logic [DATA_W-1:0] head_data;
  logic [1:0]        ready_mode;
  int unsigned       reads_issued;
  int unsigned       resps_seen;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_subsys_top UUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_addr_i   (req_addr),
    .req_write_i  (req_write),
    .req_wdata_i  (req_wdata),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .resp_rdata_o (resp_rdata),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .map_base_i   (map_base),
    .map_mask_i   (map_mask),
    .map_tgt_i    (map_tgt)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // sole driver of resp_ready, one tick after the request inputs
  always @(posedge clk) begin
    #2;
    case (ready_mode)
      READY_LOW:    resp_ready = 1'b0;
      READY_RANDOM: resp_ready = (($urandom & 32'd1) != 32'd0);
      default:      resp_ready = 1'b1;
    endcase
  end

  // response transfers are sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (rst_n === 1'b1 && resp_valid && resp_ready) begin
      assert (exp_q.size() > 0)
        else report_failure($sformatf("response at time %0t with no read outstanding", $time));
      head_data = exp_q.pop_front();
      assert (resp_rdata === head_data)
        else report_failure($sformatf("FAIL %0t: read data %h, expected %h",
                                      $time, resp_rdata, head_data));
      resps_seen++;
    end
  end

  // first matching rule wins, no match goes to the error target
  function automatic logic [TGT_IDX_W-1:0] route_target(input logic [ADDR_W-1:0] addr);
    logic [TGT_IDX_W-1:0] tgt;
    bit                   found;
    tgt   = ERR_TGT;
    found = 1'b0;
    for (int i = 0; i < NR_RULES; i++) begin
      if (!found && ((addr & map_mask[i]) == map_base[i])) begin
        tgt   = map_tgt[i];
        found = 1'b1;
      end
    end
    return tgt;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    logic [TGT_IDX_W-1:0] tgt;
    tgt = route_target(addr);
    if (tgt == 2'd0) begin
      return ref_bank0[addr[9:2]];
    end else if (tgt == 2'd1) begin
      return ref_bank1[addr[9:2]];
    end
    return ERR_DATA;
  endfunction

  function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [ADDR_W-1:0] random_addr(input bit allow_unmapped);
    logic [ADDR_W-1:0] offset;
    offset = $urandom & 32'h0000_0ffc;
    case ($urandom % (allow_unmapped ? 4 : 3))
      0:       return offset;
      1:       return 32'h0000_1000 | offset;
      2:       return 32'h0000_0100 | (offset & 32'h0000_000c);
      default: return 32'h0004_0000 | offset;
    endcase
  endfunction

  task automatic drive_request(input logic [ADDR_W-1:0] addr, input logic write,
                               input logic [DATA_W-1:0] wdata);
    req_addr  = addr;
    req_write = write;
    req_wdata = wdata;
    req_valid = 1'b1;
  endtask

  // returns just after the edge that carried the transfer, or after max_cycles
  task automatic wait_accept(input int unsigned max_cycles, output bit accepted);
    int unsigned cycles;
    accepted = 1'b0;
    cycles   = 0;
    while (!accepted && cycles < max_cycles) begin
      @(negedge clk);
      accepted = req_ready;
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bit                   accepted;
    logic [TGT_IDX_W-1:0] tgt;
    drive_request(addr, 1'b1, data);
    wait_accept(ACCEPT_TIMEOUT, accepted);
    if (!accepted) begin
      report_failure($sformatf("timeout: write to %h was never accepted", addr));
    end
    req_valid = 1'b0;
    tgt = route_target(addr);
    if (tgt == 2'd0) begin
      ref_bank0[addr[9:2]] = data;
    end else if (tgt == 2'd1) begin
      ref_bank1[addr[9:2]] = data;
    end
  endtask

  task automatic issue_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
    bit accepted;
    drive_request(addr, 1'b0, '0);
    wait_accept(ACCEPT_TIMEOUT, accepted);
    if (!accepted) begin
      report_failure($sformatf("timeout: read from %h was never accepted", addr));
    end
    exp_q.push_back(expected);
    reads_issued++;
    req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    int unsigned cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("timeout: %0d read responses never arrived", exp_q.size()));
    end
  endtask

  // every word of both banks gets a known value
  task automatic fill_banks();
    for (int i = 0; i < BANK_WORDS; i++) begin
      write_word(32'h0000_0400 + 4 * i, fill_pattern(32'h0000_0400 + 4 * i));
      write_word(32'h0000_1000 + 4 * i, fill_pattern(32'h0000_1000 + 4 * i));
    end
  endtask

  task automatic test_rule_priority();
    for (int i = 0; i < 4; i++) begin
      write_word(32'h0000_0100 + 4 * i, 32'hc0de_0000 | i);
    end
    // window lands in bank1, bank0 keeps its fill value at the same index
    for (int i = 0; i < 4; i++) begin
      issue_read(32'h0000_1100 + 4 * i, 32'hc0de_0000 | i);
      issue_read(32'h0000_0500 + 4 * i, fill_pattern(32'h0000_0500 + 4 * i));
    end
    drain_responses();
  endtask

  task automatic test_unmapped();
    write_word(32'h0004_0100, 32'h0bad_0bad);
    issue_read(32'h0004_0100, ERR_DATA);
    issue_read(32'h8000_0000, ERR_DATA);
    issue_read(32'hffff_fffc, ERR_DATA);
    issue_read(32'h0000_0500, fill_pattern(32'h0000_0500));
    issue_read(32'h0000_1100, 32'hc0de_0000);
    drain_responses();
  endtask

  task automatic test_write_read_random();
    logic [ADDR_W-1:0] addrs [16];
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = random_addr(1'b0);
      write_word(addrs[i], $urandom);
    end
    for (int i = 0; i < 16; i++) begin
      issue_read(addrs[i], expected_read(addrs[i]));
    end
    for (int i = 0; i < 8; i++) begin
      addr = random_addr(1'b0);
      write_word(addr, $urandom);
      issue_read(addr, expected_read(addr));
    end
    drain_responses();
  endtask

  task automatic test_alternating_reads();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = (i % 2 == 0) ? 32'h0000_0600 + 4 * i : 32'h0000_1600 + 4 * i;
      issue_read(addr, expected_read(addr));
    end
    drain_responses();
  endtask

  task automatic test_backpressure();
    bit accepted;
    ready_mode = READY_LOW;
    // both reads sit in bank1, so bank0 stays free and only the route FIFO can stall it
    issue_read(32'h0000_1040, expected_read(32'h0000_1040));
    issue_read(32'h0000_1080, expected_read(32'h0000_1080));
    // route FIFO is full, a posted write still goes through
    write_word(32'h0000_0440, 32'h5eed_0001);
    drive_request(32'h0000_0440, 1'b0, '0);
    wait_accept(STALL_WINDOW, accepted);
    assert (!accepted)
      else report_failure("a third read was accepted while two reads were outstanding");
    ready_mode = READY_HIGH;
    wait_accept(ACCEPT_TIMEOUT, accepted);
    if (!accepted) begin
      report_failure("timeout: held read was not accepted after releasing the response side");
    end
    exp_q.push_back(32'h5eed_0001);
    reads_issued++;
    req_valid = 1'b0;
    drain_responses();
  endtask

  task automatic test_random_mix();
    logic [ADDR_W-1:0] addr;
    ready_mode = READY_RANDOM;
    for (int i = 0; i < 60; i++) begin
      addr = random_addr(1'b1);
      if ($urandom % 3 == 0) begin
        write_word(addr, $urandom);
      end else begin
        issue_read(addr, expected_read(addr));
      end
    end
    ready_mode = READY_HIGH;
    drain_responses();
  endtask

  initial begin
    int unsigned cycles;
    req_addr     = '0;
    req_write    = 1'b0;
    req_wdata    = '0;
    req_valid    = 1'b0;
    resp_ready   = 1'b1;
    ready_mode   = READY_HIGH;
    reads_issued = 0;
    resps_seen   = 0;
    // rule 0 overlaps rule 1, rule 3 can never match
    map_base = {32'hffff_ffff, 32'h0000_1000, 32'h0000_0000, 32'h0000_0100};
    map_mask = {32'h0000_0000, 32'hffff_f000, 32'hffff_f000, 32'hffff_fff0};
    map_tgt  = {2'd0, 2'd1, 2'd0, 2'd1};
    void'($urandom(32'h9004_7d49));
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      report_failure("reset was never released");
    end
    #1;
    assert (resp_valid === 1'b0)
      else report_failure($sformatf("FAIL %0t: response valid high after reset", $time));
    fill_banks();
    test_rule_priority();
    test_unmapped();
    test_write_read_random();
    test_alternating_reads();
    test_backpressure();
    test_random_mix();
    if (exp_q.size() == 0 && resps_seen == reads_issued) begin
      $display("Test passed");
      $finish;
    end else begin
      report_failure($sformatf("%0d reads issued but %0d responses seen",
                               reads_issued, resps_seen));
    end
  end

endmodule
